// ==== files.f ====
hw/cachePkg.sv
hw/memPortIf.sv
hw/replacePolicy.sv
hw/cacheSet.sv
hw/Cache.sv
tb/tbMemory.sv
tb/cacheTb.sv

// ==== hw/Cache.sv ====
`timescale 1ns/1ps

module Cache #(
    parameter int               SETS   = 4,
    parameter int               WAYS   = 2,
    parameter cachePkg::policyE POLICY = cachePkg::FIFO
) (
    input  logic           CLK,
    input  logic           rstN,
    // Master side
    input  logic           rcValid,
    input  logic           rcRW,
    input  cachePkg::addrT rcAddr,
    input  cachePkg::dataT rcWriteData,
    output logic           rcBusy,
    output logic           rcDone,
    output logic           rcHit,
    output cachePkg::dataT rcReadData,
    // Memory side
    output logic           cmWriteValid,
    output cachePkg::addrT cmWriteAddr,
    output cachePkg::dataT cmWriteData,
    output logic           cmReadValid,
    output cachePkg::addrT cmReadAddr,
    input  logic           cmReadReady,
    input  cachePkg::dataT cmReadData
);
    import cachePkg::*;

    localparam int INDEX_W = $clog2(SETS);

    typedef logic [INDEX_W-1:0] indexT;

    indexT           lookupIndex;
    indexT           activeIdx;
    logic            accept;
    logic [SETS-1:0] doneVec;
    logic [SETS-1:0] hitVec;
    logic [SETS-1:0] readValidVec;
    logic [SETS-1:0] writeValidVec;
    dataT            readDataArr  [SETS];
    addrT            readAddrArr  [SETS];
    addrT            writeAddrArr [SETS];
    dataT            writeDataArr [SETS];

    memPortIf memPort [SETS] ();

    assign lookupIndex = rcAddr[OFFSET_WIDTH +: INDEX_W];
    assign accept      = rcValid && !rcBusy;

    ////////////////////////////////////////////////////////////
    // Request tracking
    ////////////////////////////////////////////////////////////

    // Busy from acceptance through the rcDone cycle
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            rcBusy    <= 1'b0;
            activeIdx <= '0;
        end else if (accept) begin
            rcBusy    <= 1'b1;
            activeIdx <= lookupIndex;
        end else if (rcDone) begin
            rcBusy <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sets
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < SETS; i++) begin : gSet
        cacheSet #(
            .SETS      (SETS),
            .WAYS      (WAYS),
            .POLICY    (POLICY),
            .SET_INDEX (i)
        ) cacheSet_i (
            .CLK         (CLK),
            .rstN        (rstN),
            .lookupValid (accept && lookupIndex == indexT'(i)),
            .rcRW        (rcRW),
            .rcAddr      (rcAddr),
            .rcWriteData (rcWriteData),
            .rcDone      (doneVec[i]),
            .rcHit       (hitVec[i]),
            .rcReadData  (readDataArr[i]),
            .mem         (memPort[i].cacheSide)
        );

        // Only the owning set sees the memory answer
        assign memPort[i].readReady = cmReadReady && activeIdx == indexT'(i);
        assign memPort[i].readData  = cmReadData;

        assign readValidVec[i]  = memPort[i].readValid;
        assign readAddrArr[i]   = memPort[i].readAddr;
        assign writeValidVec[i] = memPort[i].writeValid;
        assign writeAddrArr[i]  = memPort[i].writeAddr;
        assign writeDataArr[i]  = memPort[i].writeData;
    end

    // Output mux follows the registered index
    assign rcDone       = doneVec[activeIdx];
    assign rcHit        = hitVec[activeIdx];
    assign rcReadData   = readDataArr[activeIdx];
    assign cmReadValid  = readValidVec[activeIdx];
    assign cmReadAddr   = readAddrArr[activeIdx];
    assign cmWriteValid = writeValidVec[activeIdx];
    assign cmWriteAddr  = writeAddrArr[activeIdx];
    assign cmWriteData  = writeDataArr[activeIdx];

    singleSetDone: assert property (@(posedge CLK) disable iff (!rstN)
        $onehot0(doneVec));

endmodule

// ==== hw/cachePkg.sv ====
package cachePkg;

    ////////////////////////////////////////////////////////////
    // Fixed widths
    ////////////////////////////////////////////////////////////

    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    // Byte offset inside one 32-bit word
    localparam int OFFSET_WIDTH = 2;

    typedef logic [ADDR_WIDTH-1:0] addrT;
    typedef logic [DATA_WIDTH-1:0] dataT;

    ////////////////////////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////////////////////////

    // Victim selection when a set is full
    typedef enum logic {
        FIFO,
        LRU
    } policyE;

    // Per-set miss sequencing
    typedef enum logic [1:0] {
        IDLE,
        RESPOND,
        WRITEBACK,
        FETCH
    } setStateE;

endpackage

// ==== hw/cacheSet.sv ====
`timescale 1ns/1ps

module cacheSet #(
    parameter int               SETS      = 4,
    parameter int               WAYS      = 2,
    parameter cachePkg::policyE POLICY    = cachePkg::FIFO,
    parameter int               SET_INDEX = 0
) (
    input  logic           CLK,
    input  logic           rstN,
    input  logic           lookupValid,
    input  logic           rcRW,
    input  cachePkg::addrT rcAddr,
    input  cachePkg::dataT rcWriteData,
    output logic           rcDone,
    output logic           rcHit,
    output cachePkg::dataT rcReadData,
    memPortIf.cacheSide    mem
);
    import cachePkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int WAY_W   = $clog2(WAYS);
    localparam int TAG_W   = ADDR_WIDTH - INDEX_W - OFFSET_WIDTH;
    localparam logic [INDEX_W-1:0] MY_INDEX = INDEX_W'(SET_INDEX);

    typedef logic [TAG_W-1:0] tagT;
    typedef logic [WAY_W-1:0] wayT;

    ////////////////////////////////////////////////////////////
    // Way storage
    ////////////////////////////////////////////////////////////

    tagT             tags  [WAYS];
    dataT            words [WAYS];
    logic [WAYS-1:0] valid;
    logic [WAYS-1:0] dirty;

    // Request held while a miss is in progress
    setStateE state;
    tagT      reqTag;
    logic     reqRW;
    dataT     reqData;
    wayT      wayReg;
    logic     hitReg;
    dataT     respData;

    tagT             lookupTag;
    logic [WAYS-1:0] hitVec;
    logic            anyHit;
    wayT             hitWay;
    wayT             victimWay;
    dataT            fillWord;
    logic            touch;

    assign lookupTag = rcAddr[ADDR_WIDTH-1 -: TAG_W];

    always_comb begin
        anyHit = 1'b0;
        hitWay = '0;
        for (int w = 0; w < WAYS; w++) begin
            hitVec[w] = valid[w] && tags[w] == lookupTag;
            if (hitVec[w]) begin
                anyHit = 1'b1;
                hitWay = wayT'(w);
            end
        end
    end

    // A write miss merges the store word over the fetched one
    assign fillWord = reqRW ? reqData : mem.readData;

    ////////////////////////////////////////////////////////////
    // Miss FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            state  <= IDLE;
            valid  <= '0;
            dirty  <= '0;
            hitReg <= 1'b0;
            wayReg <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (lookupValid && anyHit) begin
                        state  <= RESPOND;
                        hitReg <= 1'b1;
                        wayReg <= hitWay;
                        if (rcRW) begin
                            dirty[hitWay] <= 1'b1;
                        end
                    end else if (lookupValid) begin
                        hitReg <= 1'b0;
                        wayReg <= victimWay;
                        // Dirty victim goes out first
                        if (valid[victimWay] && dirty[victimWay]) begin
                            state <= WRITEBACK;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                WRITEBACK: begin
                    state <= FETCH;
                end
                FETCH: begin
                    if (mem.readReady) begin
                        state         <= RESPOND;
                        valid[wayReg] <= 1'b1;
                        dirty[wayReg] <= reqRW;
                    end
                end
                RESPOND: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Tags, words and the captured request
    always_ff @(posedge CLK) begin
        if (state == IDLE && lookupValid) begin
            reqTag  <= lookupTag;
            reqRW   <= rcRW;
            reqData <= rcWriteData;
            if (anyHit && rcRW) begin
                words[hitWay] <= rcWriteData;
                respData      <= rcWriteData;
            end else if (anyHit) begin
                respData <= words[hitWay];
            end
        end
        if (state == FETCH && mem.readReady) begin
            tags[wayReg]  <= reqTag;
            words[wayReg] <= fillWord;
            respData      <= fillWord;
        end
    end

    // FIFO only moves on fills, LRU on every completion
    assign touch = state == RESPOND && (POLICY == LRU || !hitReg);

    replacePolicy #(
        .WAYS   (WAYS),
        .POLICY (POLICY)
    ) replacePolicy_i (
        .CLK       (CLK),
        .rstN      (rstN),
        .touch     (touch),
        .touchWay  (wayReg),
        .validMask (valid),
        .victimWay (victimWay)
    );

    assign rcDone     = state == RESPOND;
    assign rcHit      = hitReg;
    assign rcReadData = respData;

    assign mem.readValid  = state == FETCH;
    assign mem.readAddr   = {reqTag, MY_INDEX, {OFFSET_WIDTH{1'b0}}};
    assign mem.writeValid = state == WRITEBACK;
    assign mem.writeAddr  = {tags[wayReg], MY_INDEX, {OFFSET_WIDTH{1'b0}}};
    assign mem.writeData  = words[wayReg];

    noReadDuringWrite: assert property (@(posedge CLK) disable iff (!rstN)
        !(mem.readValid && mem.writeValid));

    // Top level must hold off new lookups while this set is busy
    lookupOnlyWhenIdle: assert property (@(posedge CLK) disable iff (!rstN)
        lookupValid |-> state == IDLE);

endmodule

// ==== hw/memPortIf.sv ====
`timescale 1ns/1ps

interface memPortIf;
    import cachePkg::*;

    // Driven by the set
    logic readValid;
    addrT readAddr;
    logic writeValid;
    addrT writeAddr;
    dataT writeData;

    // Driven by the top level
    logic readReady;
    dataT readData;

    modport cacheSide (
        output readValid, readAddr,
        output writeValid, writeAddr, writeData,
        input  readReady, readData
    );

    modport topSide (
        input  readValid, readAddr,
        input  writeValid, writeAddr, writeData,
        output readReady, readData
    );

endinterface

// ==== hw/replacePolicy.sv ====
`timescale 1ns/1ps

module replacePolicy #(
    parameter int               WAYS   = 2,
    parameter cachePkg::policyE POLICY = cachePkg::FIFO
) (
    input  logic                    CLK,
    input  logic                    rstN,
    input  logic                    touch,
    input  logic [$clog2(WAYS)-1:0] touchWay,
    input  logic [WAYS-1:0]         validMask,
    output logic [$clog2(WAYS)-1:0] victimWay
);
    import cachePkg::*;

    localparam int WAY_W = $clog2(WAYS);

    typedef logic [WAY_W-1:0] wayT;

    logic anyInvalid;
    wayT  firstInvalid;
    wayT  policyWay;

    // Lowest invalid way wins over the policy
    always_comb begin
        anyInvalid   = 1'b0;
        firstInvalid = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!validMask[w]) begin
                anyInvalid   = 1'b1;
                firstInvalid = wayT'(w);
            end
        end
    end

    generate
        if (POLICY == FIFO) begin : gFifo
            wayT fifoPtr;

            // Only a fill lands on the pointer way
            always_ff @(posedge CLK) begin
                if (!rstN) begin
                    fifoPtr <= '0;
                end else if (touch && touchWay == fifoPtr) begin
                    fifoPtr <= fifoPtr + 1'b1;
                end
            end

            assign policyWay = fifoPtr;
        end else begin : gLru
            wayT ages [WAYS];
            wayT oldestWay;

            // Touched way becomes youngest, younger ones age by one
            always_ff @(posedge CLK) begin
                if (!rstN) begin
                    for (int w = 0; w < WAYS; w++) begin
                        ages[w] <= '0;
                    end
                end else if (touch) begin
                    for (int w = 0; w < WAYS; w++) begin
                        if (wayT'(w) == touchWay) begin
                            ages[w] <= '0;
                        end else if (ages[w] <= ages[touchWay] && ages[w] != wayT'(WAYS - 1)) begin
                            ages[w] <= ages[w] + 1'b1;
                        end
                    end
                end
            end

            // Oldest age, lowest index on a tie
            always_comb begin
                oldestWay = '0;
                for (int w = 1; w < WAYS; w++) begin
                    if (ages[w] > ages[oldestWay]) begin
                        oldestWay = wayT'(w);
                    end
                end
            end

            assign policyWay = oldestWay;
        end
    endgenerate

    assign victimWay = anyInvalid ? firstInvalid : policyWay;

    touchWayInRange: assert property (@(posedge CLK) disable iff (!rstN)
        touch |-> int'(touchWay) < WAYS);

endmodule

// ==== tb/cacheTb.sv ====
`timescale 1ns/1ps

module cacheTb;
    import cachePkg::*;

    localparam int   SETS     = 4;
    localparam int   WAYS     = 2;
    localparam int   WINDOW   = 16;
    localparam int   REQUESTS = 2000;
    localparam int   TIMEOUT  = 200;
    localparam int   TAG_W    = ADDR_WIDTH - $clog2(SETS) - OFFSET_WIDTH;
    localparam addrT BASE     = 32'h0000_1000;
    localparam dataT KEY      = 32'h5A3C_96E1;

    logic CLK = 1'b0;
    logic rstN;
    logic rcValid, rcRW, rcBusy, rcDone, rcHit;
    addrT rcAddr, cmWriteAddr, cmReadAddr;
    dataT rcWriteData, rcReadData, cmWriteData, cmReadData;
    logic cmWriteValid, cmReadValid, cmReadReady;

    // Reference model of the cache contents and of main memory
    logic [TAG_W-1:0] mTag   [SETS][WAYS];
    logic             mValid [SETS][WAYS];
    logic             mDirty [SETS][WAYS];
    dataT             mData  [SETS][WAYS];
    // Window word held by each way
    int               mWord  [SETS][WAYS];
    int               mPtr   [SETS];
    dataT             modelMem   [WINDOW];
    dataT             latestWord [WINDOW];

    logic        expHit, expWb;
    addrT        expWbAddr;
    dataT        expWbData, expData;
    int          reqCount = 0;
    logic [15:0] lfsr = 16'd53;

    always #5 CLK = ~CLK;

    Cache #(.SETS(SETS), .WAYS(WAYS), .POLICY(FIFO)) Cache_i (
        .CLK(CLK), .rstN(rstN),
        .rcValid(rcValid), .rcRW(rcRW), .rcAddr(rcAddr), .rcWriteData(rcWriteData),
        .rcBusy(rcBusy), .rcDone(rcDone), .rcHit(rcHit), .rcReadData(rcReadData),
        .cmWriteValid(cmWriteValid), .cmWriteAddr(cmWriteAddr), .cmWriteData(cmWriteData),
        .cmReadValid(cmReadValid), .cmReadAddr(cmReadAddr),
        .cmReadReady(cmReadReady), .cmReadData(cmReadData)
    );

    tbMemory #(.BASE(BASE), .KEY(KEY), .WORDS(WINDOW)) memory_i (
        .CLK(CLK), .rstN(rstN),
        .readValid(cmReadValid), .readAddr(cmReadAddr),
        .readReady(cmReadReady), .readData(cmReadData),
        .writeValid(cmWriteValid), .writeAddr(cmWriteAddr), .writeData(cmWriteData)
    );

    function automatic logic [15:0] nextLfsr(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = nextLfsr(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            abortRun($sformatf("mismatch %s on request %0d expected %h actual %h",
                               name, reqCount, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model of a write-back, write-allocate cache with FIFO victims
    ////////////////////////////////////////////////////////////

    task automatic predict(input logic rw, input logic [3:0] idx, input dataT wdata);
        logic [1:0]       s;
        logic [TAG_W-1:0] tag;
        addrT             addr;
        int               victim;
        s       = idx[1:0];
        addr    = BASE + 32'({idx, 2'b00});
        tag     = addr[ADDR_WIDTH-1 -: TAG_W];
        expHit  = 1'b0;
        expWb   = 1'b0;
        victim  = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (mValid[s][w] && mTag[s][w] == tag) begin
                expHit = 1'b1;
                victim = w;
            end
        end
        if (expHit && rw) begin
            mData[s][victim]  = wdata;
            mDirty[s][victim] = 1'b1;
        end else if (!expHit) begin
            // Lowest invalid way first, else the FIFO pointer
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!mValid[s][w]) begin
                    victim = w;
                end
            end
            if (victim < 0) begin
                victim = mPtr[s];
            end
            if (mValid[s][victim] && mDirty[s][victim]) begin
                expWb     = 1'b1;
                expWbAddr = BASE + 32'(mWord[s][victim]) * 4;
                expWbData = mData[s][victim];
                modelMem[mWord[s][victim]] = expWbData;
            end
            mTag[s][victim]   = tag;
            mWord[s][victim]  = int'(idx);
            mValid[s][victim] = 1'b1;
            mDirty[s][victim] = rw;
            mData[s][victim]  = rw ? wdata : modelMem[idx];
            if (victim == mPtr[s]) begin
                mPtr[s] = (mPtr[s] + 1) % WAYS;
            end
        end
        if (rw) begin
            latestWord[idx] = wdata;
        end
        expData = latestWord[idx];
    endtask

    // Request held until rcDone, checking the memory side on the way
    task automatic runRequest(input logic rw, input logic [3:0] idx,
                              input logic [1:0] offset, input dataT wdata);
        addrT wordAddr;
        int   cycles;
        int   wbCount;
        logic readSeen;
        logic done;
        wordAddr = BASE + 32'({idx, 2'b00});
        reqCount++;
        predict(rw, idx, wdata);
        @(posedge CLK);
        rcValid     <= 1'b1;
        rcRW        <= rw;
        rcAddr      <= wordAddr | 32'(offset);
        rcWriteData <= wdata;
        @(negedge CLK);
        check("busy before accept", 0, rcBusy);
        check("done pulse width", 0, rcDone);
        cycles   = 0;
        wbCount  = 0;
        readSeen = 1'b0;
        done     = 1'b0;
        while (!done) begin
            @(negedge CLK);
            cycles++;
            if (cycles > TIMEOUT) begin
                abortRun($sformatf("timeout waiting for rcDone on request %0d", reqCount));
            end
            check("busy in flight", 1, rcBusy);
            if (cmWriteValid) begin
                wbCount++;
                check("writeback expected", expWb, 1);
                check("writeback cycle", 1, cycles);
                check("writeback address", expWbAddr, cmWriteAddr);
                check("writeback data", expWbData, cmWriteData);
            end
            if (cmReadValid) begin
                check("fetch only on miss", !expHit, 1);
                check("read address", wordAddr, cmReadAddr);
                if (!readSeen) begin
                    check("read start cycle", expWb ? 2 : 1, cycles);
                end
                readSeen = 1'b1;
            end
            if (rcDone) begin
                done = 1'b1;
                check("hit", expHit, rcHit);
                check("data", expData, rcReadData);
                check("writeback count", expWb, wbCount);
                check("fetch issued", !expHit, readSeen);
                if (expHit) begin
                    check("hit latency", 1, cycles);
                end
            end
        end
    endtask

    initial begin
        logic       rw;
        logic [3:0] idx;
        logic [1:0] offset;
        dataT       wdata;
        rstN        = 1'b0;
        rcValid     = 1'b0;
        rcRW        = 1'b0;
        rcAddr      = '0;
        rcWriteData = '0;
        for (int s = 0; s < SETS; s++) begin
            mPtr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                mValid[s][w] = 1'b0;
                mDirty[s][w] = 1'b0;
                mTag[s][w]   = '0;
                mData[s][w]  = '0;
                mWord[s][w]  = 0;
            end
        end
        for (int i = 0; i < WINDOW; i++) begin
            modelMem[i]   = (BASE + 32'(i) * 4) ^ KEY;
            latestWord[i] = modelMem[i];
        end
        repeat (10) @(posedge CLK);
        rstN <= 1'b1;
        @(negedge CLK);
        check("reset busy", 0, rcBusy);
        check("reset done", 0, rcDone);
        check("reset read valid", 0, cmReadValid);
        check("reset write valid", 0, cmWriteValid);

        for (int n = 0; n < REQUESTS; n++) begin
            rw     = 1'(randomBits(1));
            idx    = 4'(randomBits(4));
            offset = 2'(randomBits(2));
            wdata  = randomBits(32);
            runRequest(rw, idx, offset, wdata);
        end

        // Final sweep reads back the whole window
        for (int i = 0; i < WINDOW; i++) begin
            runRequest(1'b0, 4'(i), 2'b00, '0);
        end
        @(posedge CLK);
        rcValid <= 1'b0;
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== tb/tbMemory.sv ====
`timescale 1ns/1ps

module tbMemory #(
    parameter cachePkg::addrT BASE  = 32'h0000_1000,
    parameter cachePkg::dataT KEY   = 32'h5A3C_96E1,
    parameter int             WORDS = 16
) (
    input  logic           CLK,
    input  logic           rstN,
    input  logic           readValid,
    input  cachePkg::addrT readAddr,
    output logic           readReady,
    output cachePkg::dataT readData,
    input  logic           writeValid,
    input  cachePkg::addrT writeAddr,
    input  cachePkg::dataT writeData
);
    import cachePkg::*;

    dataT        words [WORDS];
    logic [15:0] lfsr     = 16'd53;
    logic        waiting  = 1'b0;
    logic [2:0]  delay    = '0;
    logic [2:0]  newDelay = '0;
    logic        readyReg = 1'b0;
    dataT        dataReg  = '0;

    function automatic logic [15:0] nextLfsr(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic int wordIndex(input addrT addr);
        return int'((addr - BASE) >> 2) % WORDS;
    endfunction

    // Each word starts as its byte address scrambled by the key
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            words[i] = (BASE + 32'(i) * 4) ^ KEY;
        end
    end

    always @(posedge CLK) begin
        if (!rstN) begin
            waiting  <= 1'b0;
            readyReg <= 1'b0;
        end else begin
            readyReg <= 1'b0;
            if (writeValid) begin
                words[wordIndex(writeAddr)] <= writeData;
            end
            if (readValid && !readyReg) begin
                if (!waiting) begin
                    // Three LFSR bits pick an extra delay of 0 to 7
                    for (int b = 0; b < 3; b++) begin
                        lfsr     = nextLfsr(lfsr);
                        newDelay = {newDelay[1:0], lfsr[0]};
                    end
                    delay   <= newDelay;
                    waiting <= 1'b1;
                end else if (delay == 0) begin
                    readyReg <= 1'b1;
                    dataReg  <= words[wordIndex(readAddr)];
                    waiting  <= 1'b0;
                end else begin
                    delay <= delay - 1'b1;
                end
            end
        end
    end

    assign readReady = readyReg;
    assign readData  = dataReg;

endmodule
